// ==== Makefile ====
# Verilator build and run of the pipeline testbench

SIM := obj_dir/Vpipe_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module pipe_core_tb -f build.f

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

// ==== build.f ====
hw/core_pkg.sv
hw/isa_pkg.sv
hw/stage_if.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/pipe_core.sv
tests/pipe_core_chk.sv
tests/pipe_core_tb.sv

// ==== hw/core_pkg.sv ====
// Core-wide constants
// Data width default, register count, index width and ALU operation codes

`default_nettype none

package core_pkg;

  // Data path width used unless the top level overrides it
  localparam int xlen_default = 32;

  // Architectural register file
  localparam int num_regs  = 32;
  localparam int reg_idx_w = 5;

  // ALU operation encoding
  localparam int alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and  = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or   = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor  = 4'd4;
  localparam logic [alu_op_w-1:0] alu_sll  = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl  = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra  = 4'd7;
  localparam logic [alu_op_w-1:0] alu_slt  = 4'd8;
  localparam logic [alu_op_w-1:0] alu_sltu = 4'd9;

endpackage

`default_nettype wire

// ==== hw/decode_stage.sv ====
// Decode stage
// Instruction capture, opcode and funct decode to ALU code,
// immediate sign extension, register read and the issue register

`default_nettype none

module decode_stage #(
  parameter int XLEN = core_pkg::xlen_default
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid,
  input  isa_pkg::instr_u instr,
  issue_if.decode         iss,
  rf_read_if.decode       rf
);
  import core_pkg::*;
  import isa_pkg::*;

  logic                in_valid;
  instr_u              in_word;
  logic                is_op;
  logic                is_op_imm;
  logic                alt;
  logic                dec_valid;
  logic [alu_op_w-1:0] dec_op;
  logic [XLEN-1:0]     imm_ext;

  // Strobe capture
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      in_valid <= 1'b0;
    else
      in_valid <= instr_valid;
  end

  always_ff @(posedge clk)
  begin
    in_word <= instr;
  end

  assign is_op     = (in_word.r.opcode == opc_op);
  assign is_op_imm = (in_word.i.opcode == opc_op_imm);

  // Same bit as imm[10] in the I view, so srai is selected here too
  assign alt = in_word.r.funct7[alt_bit];

  always_comb
  begin
    case (in_word.r.funct3)
      f3_add_sub: dec_op = (is_op && alt) ? alu_sub : alu_add;
      f3_sll:     dec_op = alu_sll;
      f3_slt:     dec_op = alu_slt;
      f3_sltu:    dec_op = alu_sltu;
      f3_xor:     dec_op = alu_xor;
      f3_srl_sra: dec_op = alt ? alu_sra : alu_srl;
      f3_or:      dec_op = alu_or;
      f3_and:     dec_op = alu_and;
      default:    dec_op = alu_add;
    endcase
  end

  assign imm_ext = {{(XLEN-12){in_word.i.imm[11]}}, in_word.i.imm};

  // Only ALU opcodes with a real destination ever write back
  assign dec_valid = in_valid && (is_op || is_op_imm) && (in_word.r.rd != '0);

  // Read ports, write-through already applied by the register file
  assign rf.rs1_idx = in_word.r.rs1;
  assign rf.rs2_idx = in_word.r.rs2;

  // Issue register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      iss.valid <= 1'b0;
    else
      iss.valid <= dec_valid;
  end

  always_ff @(posedge clk)
  begin
    iss.alu_op  <= dec_op;
    iss.rd      <= in_word.r.rd;
    iss.rs1     <= in_word.r.rs1;
    iss.rs2     <= in_word.r.rs2;
    iss.op_a    <= rf.rs1_data;
    iss.op_b    <= is_op_imm ? imm_ext : rf.rs2_data;
    iss.use_imm <= is_op_imm;
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
// Execute stage
// Operand forwarding from the execute and write-back registers,
// the integer ALU and the execute result register

`default_nettype none

module execute_stage #(
  parameter int XLEN = core_pkg::xlen_default
) (
  input  logic                          clk,
  input  logic                          rst_n,
  issue_if.execute                      iss,
  input  logic                          wb_valid,
  input  logic [core_pkg::reg_idx_w-1:0] wb_idx,
  input  logic [XLEN-1:0]               wb_data,
  output logic                          ex_valid,
  output logic [core_pkg::reg_idx_w-1:0] ex_rd,
  output logic [XLEN-1:0]               ex_result
);
  import core_pkg::*;

  localparam int shamt_w = $clog2(XLEN);

  logic [XLEN-1:0]    opnd_a;
  logic [XLEN-1:0]    opnd_b;
  logic [shamt_w-1:0] shamt;
  logic               lt_s;
  logic               lt_u;
  logic [XLEN-1:0]    alu_out;

  // Youngest older producer wins: execute register, then write-back
  always_comb
  begin
    if (ex_valid && (ex_rd == iss.rs1))
      opnd_a = ex_result;
    else if (wb_valid && (wb_idx == iss.rs1))
      opnd_a = wb_data;
    else
      opnd_a = iss.op_a;
  end

  // Immediate operand is never replaced
  always_comb
  begin
    if (iss.use_imm)
      opnd_b = iss.op_b;
    else if (ex_valid && (ex_rd == iss.rs2))
      opnd_b = ex_result;
    else if (wb_valid && (wb_idx == iss.rs2))
      opnd_b = wb_data;
    else
      opnd_b = iss.op_b;
  end

  assign shamt = opnd_b[shamt_w-1:0];
  assign lt_s  = $signed(opnd_a) < $signed(opnd_b);
  assign lt_u  = opnd_a < opnd_b;

  always_comb
  begin
    case (iss.alu_op)
      alu_add:  alu_out = opnd_a + opnd_b;
      alu_sub:  alu_out = opnd_a - opnd_b;
      alu_and:  alu_out = opnd_a & opnd_b;
      alu_or:   alu_out = opnd_a | opnd_b;
      alu_xor:  alu_out = opnd_a ^ opnd_b;
      alu_sll:  alu_out = opnd_a << shamt;
      alu_srl:  alu_out = opnd_a >> shamt;
      alu_sra:  alu_out = $signed(opnd_a) >>> shamt;
      alu_slt:  alu_out = {{(XLEN-1){1'b0}}, lt_s};
      alu_sltu: alu_out = {{(XLEN-1){1'b0}}, lt_u};
      default:  alu_out = '0;
    endcase
  end

  // Result register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ex_valid <= 1'b0;
    else
      ex_valid <= iss.valid;
  end

  always_ff @(posedge clk)
  begin
    ex_rd     <= iss.rd;
    ex_result <= alu_out;
  end

endmodule

`default_nettype wire

// ==== hw/isa_pkg.sv ====
// RV32 integer ALU instruction encoding
// Opcodes, funct3 values, alt bit and the R/I instruction union

`default_nettype none

package isa_pkg;

  // Register-register and register-immediate ALU opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;

  // funct3 groups
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7 bit that turns add into sub and srl into sra (instr[30])
  localparam int alt_bit = 5;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Same 32-bit word, seen as R or I format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

`default_nettype wire

// ==== hw/pipe_core.sv ====
// Three-stage integer pipeline top level
// Decode, execute and result stages joined by the stage interfaces

`default_nettype none

module pipe_core #(
  parameter int XLEN = core_pkg::xlen_default
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          instr_valid,
  input  logic [31:0]                   instr,
  output logic                          wb_valid,
  output logic [core_pkg::reg_idx_w-1:0] wb_idx,
  output logic [XLEN-1:0]               wb_data
);

  // Execute to result
  logic                          ex_valid;
  logic [core_pkg::reg_idx_w-1:0] ex_rd;
  logic [XLEN-1:0]               ex_result;

  issue_if   #(.XLEN(XLEN)) iss_bus ();
  rf_read_if #(.XLEN(XLEN)) rf_bus ();

  decode_stage #(.XLEN(XLEN)) u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .iss         (iss_bus.decode),
    .rf          (rf_bus.decode)
  );

  // Write-back also feeds the forwarding path
  execute_stage #(.XLEN(XLEN)) u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .iss       (iss_bus.execute),
    .wb_valid  (wb_valid),
    .wb_idx    (wb_idx),
    .wb_data   (wb_data),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_result (ex_result)
  );

  result_stage #(.XLEN(XLEN)) u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_result (ex_result),
    .rf        (rf_bus.result),
    .wb_valid  (wb_valid),
    .wb_idx    (wb_idx),
    .wb_data   (wb_data)
  );

endmodule

`default_nettype wire

// ==== hw/result_stage.sv ====
// Result stage
// Write-back register and the architectural register file,
// with write-through of the pending write-back on both read ports

`default_nettype none

module result_stage #(
  parameter int XLEN = core_pkg::xlen_default
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ex_valid,
  input  logic [core_pkg::reg_idx_w-1:0] ex_rd,
  input  logic [XLEN-1:0]               ex_result,
  rf_read_if.result                     rf,
  output logic                          wb_valid,
  output logic [core_pkg::reg_idx_w-1:0] wb_idx,
  output logic [XLEN-1:0]               wb_data
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [num_regs];
  logic            hit_rs1;
  logic            hit_rs2;

  // Write-back register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_valid <= 1'b0;
    else
      wb_valid <= ex_valid;
  end

  always_ff @(posedge clk)
  begin
    wb_idx  <= ex_rd;
    wb_data <= ex_result;
  end

  // Register file, all zero after reset
  // x0 stays zero since decode never issues rd == 0
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end
    else if (wb_valid)
    begin
      regs[wb_idx] <= wb_data;
    end
  end

  // The entry being written this cycle is returned directly
  assign hit_rs1 = wb_valid && (wb_idx == rf.rs1_idx);
  assign hit_rs2 = wb_valid && (wb_idx == rf.rs2_idx);

  assign rf.rs1_data = hit_rs1 ? wb_data : regs[rf.rs1_idx];
  assign rf.rs2_data = hit_rs2 ? wb_data : regs[rf.rs2_idx];

endmodule

`default_nettype wire

// ==== hw/stage_if.sv ====
// Pipeline interfaces
// issue_if carries decoded operands from decode to execute
// rf_read_if carries register-file reads between decode and the result stage

`default_nettype none

interface issue_if #(
  parameter int XLEN = core_pkg::xlen_default
);
  import core_pkg::*;

  logic                 valid;
  logic [alu_op_w-1:0]  alu_op;
  logic [reg_idx_w-1:0] rd;
  logic [reg_idx_w-1:0] rs1;
  logic [reg_idx_w-1:0] rs2;
  logic [XLEN-1:0]      op_a;
  // Holds the sign-extended immediate when use_imm is set
  logic [XLEN-1:0]      op_b;
  logic                 use_imm;

  modport decode (
    output valid, alu_op, rd, rs1, rs2, op_a, op_b, use_imm
  );

  modport execute (
    input valid, alu_op, rd, rs1, rs2, op_a, op_b, use_imm
  );

endinterface

interface rf_read_if #(
  parameter int XLEN = core_pkg::xlen_default
);
  import core_pkg::*;

  logic [reg_idx_w-1:0] rs1_idx;
  logic [reg_idx_w-1:0] rs2_idx;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;

  modport decode (
    output rs1_idx, rs2_idx,
    input  rs1_data, rs2_data
  );

  // Data returned combinationally
  modport result (
    input  rs1_idx, rs2_idx,
    output rs1_data, rs2_data
  );

endinterface

`default_nettype wire

// ==== tests/pipe_core_chk.sv ====
// Bound assertions on the pipeline top level
// Write-back timing, destination order and the x0 rule

`default_nettype none

module pipe_core_chk (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          instr_valid,
  input logic [31:0]                   instr,
  input logic                          wb_valid,
  input logic [core_pkg::reg_idx_w-1:0] wb_idx
);
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;

  logic writes;

  // Strobed ALU instruction with a real destination
  assign writes = instr_valid && (instr[11:7] != 5'd0) &&
                  ((instr[6:0] == opc_op) || (instr[6:0] == opc_op_imm));

  // Strobe sampled at edge N, wb_valid set after edge N+3, seen at edge N+4
  a_wb_timing: assert property (@(posedge clk) disable iff (!rst_n)
    $past(writes, 4) == wb_valid)
    else $error("write-back valid does not follow the strobe by 3 cycles");

  a_wb_order: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (wb_idx == $past(instr[11:7], 4)))
    else $error("write-back index differs from the strobed rd");

  a_no_x0: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (wb_idx != '0))
    else $error("write-back to register 0");

endmodule

bind pipe_core pipe_core_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .instr_valid (instr_valid),
  .instr       (instr),
  .wb_valid    (wb_valid),
  .wb_idx      (wb_idx)
);

`default_nettype wire

// ==== tests/pipe_core_tb.sv ====
// Testbench for the three-stage pipeline
// Clock, reset, directed and random instruction stream,
// reference register model and write-back comparison

`default_nettype none

module pipe_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import core_pkg::*;
  import isa_pkg::*;

  localparam int n_instr     = 400;
  localparam int drain_limit = 50;

  // Hazards at distance 1 to 3, x0 reads, rd = x0 and a load opcode
  localparam logic [31:0] directed [9] = '{
    32'h003100b3,  // x1 = x2 + x3 while all still zero
    32'hffb00093,  // x1 = x0 + -5
    32'h00708113,  // x2 = x1 + 7
    32'h402081b3,  // x3 = x1 - x2
    32'h4021d233,  // x4 = x3 >>> x2
    32'h0011b2b3,  // x5 = x3 <u x1
    32'h00108033,  // rd = x0 is dropped
    32'h00012083,  // Load opcode is dropped
    32'h0011a2b3   // x5 = x3 <s x1
  };

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic                 wb_valid;
  logic [reg_idx_w-1:0] wb_idx;
  logic [31:0]          wb_data;

  logic [31:0]          model [num_regs];
  logic [reg_idx_w-1:0] exp_idx_q [$];
  logic [31:0]          exp_data_q [$];
  int                   exp_cyc_q [$];
  int                   cycle;
  int                   errors;
  int                   timeouts;

  pipe_core #(.XLEN(xlen_default)) i_pipe_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_idx      (wb_idx),
    .wb_data     (wb_data)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  // Expected write of one instruction against the current register state
  function automatic void ref_exec(
    input  logic [31:0] regs [num_regs],
    input  logic [31:0] word,
    output logic        wr,
    output logic [4:0]  idx,
    output logic [31:0] val
  );
    logic        is_r;
    logic        is_i;
    logic        alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    is_r = (word[6:0] == opc_op);
    is_i = (word[6:0] == opc_op_imm);
    alt  = word[30];
    idx  = word[11:7];
    wr   = (is_r || is_i) && (idx != 5'd0);
    a    = regs[word[19:15]];
    b    = is_i ? {{20{word[31]}}, word[31:20]} : regs[word[24:20]];
    sh   = b[4:0];
    case (word[14:12])
      f3_add_sub: val = (is_r && alt) ? a - b : a + b;
      f3_sll:     val = a << sh;
      f3_slt:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_sltu:    val = (a < b) ? 32'd1 : 32'd0;
      f3_xor:     val = a ^ b;
      f3_or:      val = a | b;
      f3_and:     val = a & b;
      default:
      begin
        if (alt)
          val = $signed(a) >>> sh;
        else
          val = a >> sh;
      end
    endcase
  endfunction

  // Registers mostly from x0 to x5 so neighbours depend on each other
  function automatic logic [31:0] rand_instr();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    int         kind;
    rd   = ($urandom_range(9) < 8) ? 5'($urandom_range(5)) : 5'($urandom);
    rs1  = 5'($urandom_range(5));
    rs2  = 5'($urandom_range(5));
    f3   = 3'($urandom);
    f7   = ($urandom_range(1) == 1) ? 7'h20 : 7'h00;
    kind = $urandom_range(9);
    if (kind < 5)
      return {f7, rs2, rs1, f3, rd, opc_op};
    else if (kind < 9)
      return {12'($urandom), rs1, f3, rd, opc_op_imm};
    return {f7, rs2, rs1, f3, rd, 7'($urandom)};
  endfunction

  task automatic issue(input logic [31:0] word);
    logic        wr;
    logic [4:0]  idx;
    logic [31:0] val;
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = word;
    ref_exec(model, word, wr, idx, val);
    if (wr)
    begin
      model[idx] = val;
      exp_idx_q.push_back(idx);
      exp_data_q.push_back(val);
      // Sampled by the strobe edge, then three stages
      exp_cyc_q.push_back(cycle + 4);
    end
  endtask

  task automatic idle();
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = $urandom;
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (wb_valid)
    begin
      if (exp_idx_q.size() == 0)
      begin
        errors++;
        $display("unexpected write-back to register %h with nothing pending", wb_idx);
      end
      else
      begin
        if (wb_idx !== exp_idx_q[0])
        begin
          errors++;
          $display("mismatch wb_idx: got %h expected %h", wb_idx, exp_idx_q[0]);
        end
        if (wb_data !== exp_data_q[0])
        begin
          errors++;
          $display("mismatch wb_data: got %h expected %h", wb_data, exp_data_q[0]);
        end
        if (cycle != exp_cyc_q[0])
        begin
          errors++;
          $display("write-back came in cycle %0d instead of %0d", cycle, exp_cyc_q[0]);
        end
        void'(exp_idx_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
    end
  end

  initial
  begin
    void'($urandom(32'h347e8331));
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    cycle       = 0;
    errors      = 0;
    timeouts    = 0;
    for (int r = 0; r < num_regs; r++)
      model[r] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet cycles first, wb_valid must stay low
    repeat (4) idle();
    foreach (directed[k])
      issue(directed[k]);
    for (int n = 0; n < n_instr; n++)
    begin
      if ($urandom_range(4) == 0)
        idle();
      issue(rand_instr());
    end
    idle();
    for (int t = 0; t < drain_limit && exp_idx_q.size() != 0; t++)
      @(negedge clk);
    if (exp_idx_q.size() != 0)
    begin
      timeouts++;
      $display("timed out with %0d write-backs still pending", exp_idx_q.size());
    end
    repeat (4) @(negedge clk);
    $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
